// File: bench/data_checker_tb.sv
`timescale 1ns/1ns

module data_checker_tb import rdmx_check_pkg::*;;

    // Fault kinds injected into one frame
    localparam int f_none      = 0;
    localparam int f_malformed = 1;
    localparam int f_header    = 2;
    localparam int f_data      = 3;
    localparam int f_md_drop   = 4;
    localparam int f_fc        = 5;

    // Fifteen frames of 25 beats plus one pattern each
    localparam int total_beats = 15 * 26;
    localparam int limit_cycles = total_beats * 4 + 2000;

    logic        clk;
    logic        resetn;
    logic [31:0] pattern_tdata;
    logic        pattern_tvalid;
    logic        pattern_tready;
    logic [beat_w-1:0] eth_tdata;
    logic        eth_tvalid;
    logic        eth_tlast;
    logic        eth_tuser;
    logic        eth_tready;
    logic [31:0] frame_size;
    logic [63:0] rfd_addr;
    logic [63:0] rfd_size;
    logic [63:0] rmd_addr;
    logic [63:0] rmd_size;
    logic [63:0] rfc_addr;
    logic [63:0] total_packets_rcvd;
    logic [63:0] malformed_packets;
    logic [31:0] expected_fc;
    logic [31:0] expected_frame_pattern;
    logic [31:0] error;
    logic        all_good;

    // Model state
    logic [31:0] lfsr;
    logic [15:0] m_seq;
    logic [63:0] m_fd_off;
    logic [63:0] m_md_off;
    logic [31:0] m_fc;
    int          fault_mode;
    int          fault_kind;
    int          fault_field;
    int          fault_pkt;
    int          fault_beat;
    int          checks;
    int          errors;

    data_checker #(.fd_packet_bytes(256)) dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Watchdog sized from the total beat count of all tests
    initial begin
        #(limit_cycles * 40);
        $display("Timeout: the DUT stopped accepting data");
        $display("** FAIL **");
        $finish;
    end

    //========================================================================
    // Random numbers and checks
    //========================================================================
    function automatic logic lfsr_bit();
        logic b;
        b = lfsr[0];
        lfsr = lfsr >> 1;
        if (b) lfsr = lfsr ^ 32'h80200003;
        return b;
    endfunction

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) r = {r[30:0], lfsr_bit()};
        return r;
    endfunction

    task automatic check_value(string name, logic [63:0] exp, logic [63:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("Error %s: expected %0h, actual %0h", name, exp, act);
        end
    endtask

    // First wire byte sits in the low byte of tdata
    function automatic logic [beat_w-1:0] to_wire(logic [beat_w-1:0] v);
        logic [beat_w-1:0] w;
        for (int i = 0; i < beat_bytes; i++) w[8*i +: 8] = v[beat_w-1-8*i -: 8];
        return w;
    endfunction

    // Error bit that a header fault of one kind and field must raise
    function automatic int header_bit(int kind, int field);
        if (field == 4) return err_bad_fd_flags + kind;
        return kind * 6 + field;
    endfunction

    //========================================================================
    // Stream drivers, each driving its inputs just after a rising edge
    //========================================================================
    task automatic apply_reset();
        @(posedge clk);
        resetn         <= 1'b0;
        pattern_tvalid <= 1'b0;
        eth_tvalid     <= 1'b0;
        eth_tlast      <= 1'b0;
        eth_tuser      <= 1'b0;
        repeat (5) @(posedge clk);
        resetn <= 1'b1;
        @(posedge clk);
        m_seq    = 16'd1;
        m_fd_off = '0;
        m_md_off = '0;
        m_fc     = '0;
    endtask

    task automatic send_pattern(logic [31:0] pat);
        @(posedge clk);
        pattern_tdata  <= pat;
        pattern_tvalid <= 1'b1;
        @(negedge clk);
        while (!pattern_tready) @(negedge clk);
        @(posedge clk);
        pattern_tvalid <= 1'b0;
    endtask

    task automatic send_beat(logic [beat_w-1:0] d, logic last, logic user);
        // Now and then an idle cycle goes before the beat
        if (rand_bits(2) == 32'd0) begin
            eth_tvalid <= 1'b0;
            @(posedge clk);
        end
        eth_tdata  <= d;
        eth_tlast  <= last;
        eth_tuser  <= user;
        eth_tvalid <= 1'b1;
        @(negedge clk);
        while (!eth_tready) @(negedge clk);
        @(posedge clk);
    endtask

    task automatic send_header(int kind, int idx, logic user);
        rdmx_hdr_t h;
        logic      corrupt;
        h = '0;
        h.dst_mac    = 48'(rand_bits(32));
        h.src_mac    = 48'(rand_bits(32));
        h.frame_type = 16'h0800;
        h.magic      = rdmx_magic;
        h.seq_num    = m_seq;
        h.user_fld   = rand_bits(32);
        case (kind)
            0: begin
                h.address    = rfd_addr + m_fd_off;
                h.ip4_length = 16'd306;
                m_fd_off = (m_fd_off + 64'd256 < rfd_size) ? m_fd_off + 64'd256 : '0;
            end
            1: begin
                h.address    = rmd_addr + m_md_off;
                h.ip4_length = 16'd178;
                m_md_off = (m_md_off + 64'd128 < rmd_size) ? m_md_off + 64'd128 : '0;
            end
            default: begin
                h.address    = rfc_addr;
                h.ip4_length = 16'd54;
                h.flags      = 8'd1;
            end
        endcase
        corrupt = user || (fault_mode == f_header && fault_kind == kind &&
                           (kind != 0 || idx == fault_pkt));
        if (corrupt) begin
            case (fault_field)
                0: h.magic      = h.magic ^ 16'(rand_bits(15) + 32'd1);
                1: h.seq_num    = h.seq_num ^ 16'(rand_bits(15) + 32'd1);
                2: h.ip4_length = h.ip4_length + 16'd1;
                3: h.address    = h.address ^ (64'd1 << rand_bits(6));
                default: h.flags = h.flags ^ 8'(rand_bits(7) + 32'd1);
            endcase
        end
        send_beat(to_wire(beat_w'(h)), 1'b0, user);
    endtask

    task automatic send_frame(logic [31:0] pat);
        logic [beat_w-1:0] d;
        logic              user;
        int                md_len;
        int                flip_bit;
        logic [31:0]       fc_val;
        send_pattern(pat);
        m_fc = m_fc + 32'd1;
        for (int p = 0; p < 4; p++) begin
            user = (fault_mode == f_malformed && p == fault_pkt);
            send_header(0, p, user);
            for (int b = 0; b < 4; b++) begin
                d = {16{pat}};
                if (user) d = ~d;
                if (fault_mode == f_data && p == fault_pkt && b == fault_beat) begin
                    flip_bit = int'(rand_bits(9));
                    d[flip_bit] = ~d[flip_bit];
                end
                send_beat(d, b == 3, user);
            end
            m_seq = m_seq + 16'd1;
        end
        // Meta-data content is free, a dropped beat shortens the packet
        send_header(1, 0, 1'b0);
        md_len = (fault_mode == f_md_drop) ? 1 : 2;
        for (int b = 0; b < md_len; b++) begin
            send_beat({16{rand_bits(32)}}, b == md_len - 1, 1'b0);
        end
        m_seq = m_seq + 16'd1;
        send_header(2, 0, 1'b0);
        fc_val = m_fc;
        if (fault_mode == f_fc) fc_val = fc_val ^ (rand_bits(31) + 32'd1);
        send_beat({{15{rand_bits(32)}}, fc_val}, 1'b1, 1'b0);
        m_seq = m_seq + 16'd1;
        eth_tvalid <= 1'b0;
        eth_tlast  <= 1'b0;
        eth_tuser  <= 1'b0;
        repeat (4) @(negedge clk);
    endtask

    //========================================================================
    // Test sequence
    //========================================================================
    initial begin
        logic [31:0] pat;
        int          bit_no;
        lfsr       = 32'd25;
        checks     = 0;
        errors     = 0;
        fault_mode = f_none;
        fault_kind = 0;
        fault_field = 0;
        fault_pkt  = 0;
        fault_beat = 0;
        resetn     = 1'b0;
        pattern_tdata  = '0;
        pattern_tvalid = 1'b0;
        eth_tdata  = '0;
        eth_tvalid = 1'b0;
        eth_tlast  = 1'b0;
        eth_tuser  = 1'b0;
        frame_size = 32'd2048;
        rfd_addr   = 64'h0000_0010_0000_0000;
        rfd_size   = 64'h0010_0000;
        rmd_addr   = 64'h0000_0020_0000_0000;
        rmd_size   = 64'h0010_0000;
        rfc_addr   = 64'h0000_0030_0000_0040;
        @(posedge clk);

        // Clean frames
        apply_reset();
        for (int f = 0; f < 3; f++) begin
            pat = rand_bits(32);
            send_frame(pat);
        end
        check_value("clean error", 64'd0, 64'(error));
        check_value("clean all_good", 64'd1, 64'(all_good));
        check_value("clean expected_fc", 64'd3, 64'(expected_fc));
        check_value("clean total_packets", 64'd18, total_packets_rcvd);
        check_value("clean pattern", 64'(pat), 64'(expected_frame_pattern));

        // Address rings that wrap every two packets and every payload
        apply_reset();
        rfd_size <= 64'd512;
        rmd_size <= 64'd128;
        for (int f = 0; f < 2; f++) send_frame(rand_bits(32));
        check_value("wrap error", 64'd0, 64'(error));
        check_value("wrap total_packets", 64'd12, total_packets_rcvd);

        // One frame-data packet with a bad FCS and garbage inside
        apply_reset();
        rfd_size    <= 64'h0010_0000;
        rmd_size    <= 64'h0010_0000;
        fault_mode  = f_malformed;
        fault_pkt   = int'(rand_bits(2));
        fault_field = 3;
        send_frame(rand_bits(32));
        check_value("malformed error", 64'd0, 64'(error));
        check_value("malformed count", 64'd1, malformed_packets);
        check_value("malformed total_packets", 64'd6, total_packets_rcvd);

        // Header faults, one field of one packet class per run
        for (int r = 0; r < 6; r++) begin
            apply_reset();
            fault_mode  = f_header;
            fault_kind  = int'(rand_bits(2)) % 3;
            fault_field = int'(rand_bits(3)) % 5;
            fault_pkt   = int'(rand_bits(2));
            send_frame(rand_bits(32));
            bit_no = header_bit(fault_kind, fault_field);
            check_value("header error", 64'd1 << bit_no, 64'(error));
            check_value("header all_good", 64'd0, 64'(all_good));
            check_value("header pattern_tready", 64'd1, 64'(pattern_tready));
            check_value("header eth_tready", 64'd1, 64'(eth_tready));
        end

        // Payload faults
        apply_reset();
        fault_mode = f_data;
        fault_pkt  = int'(rand_bits(2));
        fault_beat = int'(rand_bits(2));
        send_frame(rand_bits(32));
        check_value("fd data error", 64'd1 << err_bad_fd, 64'(error));

        apply_reset();
        fault_mode = f_md_drop;
        send_frame(rand_bits(32));
        check_value("md length error", 64'd1 << err_bad_md_plen, 64'(error));

        apply_reset();
        fault_mode = f_fc;
        send_frame(rand_bits(32));
        check_value("fc value error", 64'd1 << err_bad_fc, 64'(error));

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: data_checker.f
verilog/rdmx_check_pkg.sv
verilog/beat_register.sv
verilog/rdmx_addr_ring.sv
verilog/rdmx_header_check.sv
verilog/packet_sequencer.sv
verilog/data_checker.sv
bench/data_checker_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the data_checker testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f data_checker.f --top-module data_checker_tb \
    -o data_checker_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "Build failed, see build.log"
    exit 1
fi

./obj_dir/data_checker_sim > sim.log 2>&1
if [ $? -ne 0 ]; then
    echo "Simulation exited with an error, see sim.log"
    exit 1
fi

if grep -q "^\*\* PASS \*\*$" sim.log; then
    echo "Simulation passed"
    exit 0
fi
echo "Simulation failed, see sim.log"
exit 1

// File: verilog/beat_register.sv
`timescale 1ns/1ns

module beat_register import rdmx_check_pkg::*; #(
    parameter int fd_packet_bytes = 256
) (
    input  logic              clk,
    input  logic [beat_w-1:0] eth_tdata,
    input  logic              eth_tvalid,
    input  logic              eth_tready,
    input  logic              eth_tlast,
    input  logic              eth_tuser,
    output logic              beat_valid,
    output logic              beat_last,
    output logic              beat_good,
    output rdmx_beat_u        beat_be,
    output logic [beat_w-1:0] beat_le
);

    logic handshake;

    // Frame-data packets must be whole beats and no larger than 8 KiB
    if (fd_packet_bytes < beat_bytes || fd_packet_bytes > 8192 ||
        (fd_packet_bytes & (fd_packet_bytes - 1)) != 0) begin : g_bad_size
        $error("fd_packet_bytes must be a power of two from 64 to 8192");
    end

    assign handshake = eth_tvalid & eth_tready;

    // The strobe follows the handshake by one cycle and lasts one cycle
    always_ff @(posedge clk) begin
        beat_valid <= handshake;
        beat_last  <= handshake & eth_tlast;
    end

    // Data and its good flag are only loaded on an accepted beat
    always_ff @(posedge clk) begin
        if (handshake) begin
            beat_le      <= eth_tdata;
            // The first wire byte lands at the top so the header reads in order
            beat_be.flat <= {<<8{eth_tdata}};
            // tuser marks a frame that failed its FCS
            beat_good    <= ~eth_tuser;
        end
    end

endmodule

// File: verilog/data_checker.sv
`timescale 1ns/1ns

module data_checker import rdmx_check_pkg::*; #(
    parameter int fd_packet_bytes = 256
) (
    input  logic              clk,
    input  logic              resetn,
    input  logic [31:0]       pattern_tdata,
    input  logic              pattern_tvalid,
    output logic              pattern_tready,
    input  logic [beat_w-1:0] eth_tdata,
    input  logic              eth_tvalid,
    input  logic              eth_tlast,
    input  logic              eth_tuser,
    output logic              eth_tready,
    input  logic [31:0]       frame_size,
    input  logic [63:0]       rfd_addr,
    input  logic [63:0]       rfd_size,
    input  logic [63:0]       rmd_addr,
    input  logic [63:0]       rmd_size,
    input  logic [63:0]       rfc_addr,
    output logic [63:0]       total_packets_rcvd,
    output logic [63:0]       malformed_packets,
    output logic [31:0]       expected_fc,
    output logic [31:0]       expected_frame_pattern,
    output logic [31:0]       error,
    output logic              all_good
);

    logic              beat_valid;
    logic              beat_last;
    logic              beat_good;
    rdmx_beat_u        beat_be;
    logic [beat_w-1:0] beat_le;
    logic              fd_advance;
    logic              md_advance;
    logic [63:0]       fd_addr;
    logic [63:0]       md_addr;
    pkt_kind_t         hdr_kind;
    logic [15:0]       expected_seq;
    logic [4:0]        hdr_fail;
    logic              waiting_pattern;
    logic              halted;

    // Patterns are taken between frames, Ethernet beats during a frame
    // After an error both streams drain so the sources never stall
    assign pattern_tready = resetn & (halted | waiting_pattern);
    assign eth_tready     = resetn & (halted | ~waiting_pattern);

    beat_register #(
        .fd_packet_bytes(fd_packet_bytes)
    ) beat_reg_i (
        .clk       (clk),
        .eth_tdata (eth_tdata),
        .eth_tvalid(eth_tvalid),
        .eth_tready(eth_tready),
        .eth_tlast (eth_tlast),
        .eth_tuser (eth_tuser),
        .beat_valid(beat_valid),
        .beat_last (beat_last),
        .beat_good (beat_good),
        .beat_be   (beat_be),
        .beat_le   (beat_le)
    );

    // Frame-data ring steps by one packet, meta-data ring by one payload
    rdmx_addr_ring #(.step_bytes(fd_packet_bytes)) fd_ring_i (
        .clk    (clk),
        .resetn (resetn),
        .advance(fd_advance),
        .base   (rfd_addr),
        .size   (rfd_size),
        .addr   (fd_addr)
    );

    rdmx_addr_ring #(.step_bytes(md_payload_bytes)) md_ring_i (
        .clk    (clk),
        .resetn (resetn),
        .advance(md_advance),
        .base   (rmd_addr),
        .size   (rmd_size),
        .addr   (md_addr)
    );

    rdmx_header_check #(
        .fd_packet_bytes(fd_packet_bytes)
    ) hdr_check_i (
        .hdr         (beat_be),
        .hdr_kind    (hdr_kind),
        .expected_seq(expected_seq),
        .fd_addr     (fd_addr),
        .md_addr     (md_addr),
        .fc_addr     (rfc_addr),
        .hdr_fail    (hdr_fail)
    );

    packet_sequencer #(
        .fd_packet_bytes(fd_packet_bytes)
    ) seq_i (
        .clk                   (clk),
        .resetn                (resetn),
        .pattern_tdata         (pattern_tdata),
        .pattern_tvalid        (pattern_tvalid),
        .beat_valid            (beat_valid),
        .beat_last             (beat_last),
        .beat_good             (beat_good),
        .beat_be               (beat_be),
        .beat_le               (beat_le),
        .frame_size            (frame_size),
        .hdr_fail              (hdr_fail),
        .hdr_kind              (hdr_kind),
        .expected_seq          (expected_seq),
        .fd_advance            (fd_advance),
        .md_advance            (md_advance),
        .waiting_pattern       (waiting_pattern),
        .halted                (halted),
        .total_packets_rcvd    (total_packets_rcvd),
        .malformed_packets     (malformed_packets),
        .expected_fc           (expected_fc),
        .expected_frame_pattern(expected_frame_pattern),
        .error                 (error),
        .all_good              (all_good)
    );

endmodule

// File: verilog/packet_sequencer.sv
`timescale 1ns/1ns

module packet_sequencer import rdmx_check_pkg::*; #(
    parameter int fd_packet_bytes = 256
) (
    input  logic              clk,
    input  logic              resetn,
    input  logic [31:0]       pattern_tdata,
    input  logic              pattern_tvalid,
    input  logic              beat_valid,
    input  logic              beat_last,
    input  logic              beat_good,
    input  rdmx_beat_u        beat_be,
    input  logic [beat_w-1:0] beat_le,
    input  logic [31:0]       frame_size,
    input  logic [4:0]        hdr_fail,
    output pkt_kind_t         hdr_kind,
    output logic [15:0]       expected_seq,
    output logic              fd_advance,
    output logic              md_advance,
    output logic              waiting_pattern,
    output logic              halted,
    output logic [63:0]       total_packets_rcvd,
    output logic [63:0]       malformed_packets,
    output logic [31:0]       expected_fc,
    output logic [31:0]       expected_frame_pattern,
    output logic [31:0]       error,
    output logic              all_good
);

    // A half-frame is half of frame_size, split into frame-data packets
    localparam int fd_shift = $clog2(fd_packet_bytes) + 1;

    // Payload beats per packet for each class
    localparam int fd_beats = fd_packet_bytes / beat_bytes;
    localparam int md_beats = md_payload_bytes / beat_bytes;
    localparam int fc_beats = (fc_payload_bytes + beat_bytes - 1) / beat_bytes;

    seq_state_t        state;
    logic [31:0]       hf_packets;
    logic [31:0]       fd_packet_count;
    logic [15:0]       beat_count;
    logic [31:0]       err_set;
    logic [beat_w-1:0] expected_data;
    logic [31:0]       rx_fc;
    logic              check;

    assign hf_packets    = frame_size >> fd_shift;
    assign expected_data = {(beat_w / 32){expected_frame_pattern}};

    // The counter sits in the first payload bytes, so it is the top of the
    // swapped view with its bytes put back in wire order
    assign rx_fc = {<<8{beat_be.flat[beat_w-1 -: 32]}};

    // Only beats from frames with a good FCS are checked
    assign check = beat_valid & beat_good;

    assign waiting_pattern = (state == st_get_pattern);
    assign halted          = (error != '0);
    assign all_good        = ~halted;

    always_comb begin
        case (state)
            st_fd_header: hdr_kind = kind_fd;
            st_md_header: hdr_kind = kind_md;
            default:      hdr_kind = kind_fc;
        endcase
    end

    //==========================================================================
    // Error bits raised by the current registered beat
    //==========================================================================
    always_comb begin
        err_set = '0;
        if (check) begin
            case (state)
                st_fd_header: begin
                    err_set[err_bad_fd_magic] = hdr_fail[0];
                    err_set[err_bad_fd_seq]   = hdr_fail[1];
                    err_set[err_bad_fd_psize] = hdr_fail[2];
                    err_set[err_bad_fd_taddr] = hdr_fail[3];
                    err_set[err_bad_fd_flags] = hdr_fail[4];
                end
                st_fd_packet: begin
                    err_set[err_bad_fd]      = (beat_le != expected_data);
                    err_set[err_bad_fd_plen] = beat_last && (beat_count != 16'(fd_beats));
                end
                st_md_header: begin
                    err_set[err_bad_md_magic] = hdr_fail[0];
                    err_set[err_bad_md_seq]   = hdr_fail[1];
                    err_set[err_bad_md_psize] = hdr_fail[2];
                    err_set[err_bad_md_taddr] = hdr_fail[3];
                    err_set[err_bad_md_flags] = hdr_fail[4];
                end
                st_md_packet: begin
                    // Meta-data content is free, only its length is checked
                    err_set[err_bad_md_plen] = beat_last && (beat_count != 16'(md_beats));
                end
                st_fc_header: begin
                    err_set[err_bad_fc_magic] = hdr_fail[0];
                    err_set[err_bad_fc_seq]   = hdr_fail[1];
                    err_set[err_bad_fc_psize] = hdr_fail[2];
                    err_set[err_bad_fc_taddr] = hdr_fail[3];
                    err_set[err_bad_fc_flags] = hdr_fail[4];
                end
                st_fc_packet: begin
                    err_set[err_bad_fc]      = (rx_fc != expected_fc);
                    err_set[err_bad_fc_plen] = beat_last && (beat_count != 16'(fc_beats));
                end
                default: begin
                end
            endcase
        end
    end

    //==========================================================================
    // Packet walk, error latch and counters
    //==========================================================================
    always_ff @(posedge clk) begin
        // Ring advance requests are single-cycle pulses
        fd_advance <= 1'b0;
        md_advance <= 1'b0;

        if (!resetn) begin
            state              <= st_get_pattern;
            error              <= '0;
            expected_fc        <= '0;
            expected_seq       <= 16'd1;
            total_packets_rcvd <= '0;
            malformed_packets  <= '0;
        end else begin
            // Bad-FCS frames are counted even once checking has stopped
            if (beat_valid && beat_last && !beat_good) begin
                malformed_packets <= malformed_packets + 64'd1;
            end

            if (!halted) begin
                error <= error | err_set;

                // Payload beats in this packet, one-based
                if (beat_valid) begin
                    beat_count <= beat_count + 16'd1;
                end

                if (beat_valid && beat_last) begin
                    total_packets_rcvd <= total_packets_rcvd + 64'd1;
                    expected_seq       <= expected_seq + 16'd1;
                end

                case (state)
                    st_get_pattern: begin
                        // pattern_tready is high here, so tvalid is the handshake
                        if (pattern_tvalid) begin
                            expected_frame_pattern <= pattern_tdata;
                            expected_fc            <= expected_fc + 32'd1;
                            fd_packet_count        <= '0;
                            state                  <= st_fd_header;
                        end
                    end
                    st_fd_header: begin
                        if (beat_valid) begin
                            fd_advance      <= 1'b1;
                            fd_packet_count <= fd_packet_count + 32'd1;
                            beat_count      <= 16'd1;
                            state           <= st_fd_packet;
                        end
                    end
                    st_fd_packet: begin
                        // After the last packet of the half-frame comes meta-data
                        if (beat_valid && beat_last) begin
                            if (fd_packet_count == hf_packets) begin
                                state <= st_md_header;
                            end else begin
                                state <= st_fd_header;
                            end
                        end
                    end
                    st_md_header: begin
                        if (beat_valid) begin
                            md_advance <= 1'b1;
                            beat_count <= 16'd1;
                            state      <= st_md_packet;
                        end
                    end
                    st_md_packet: begin
                        if (beat_valid && beat_last) begin
                            state <= st_fc_header;
                        end
                    end
                    st_fc_header: begin
                        if (beat_valid) begin
                            beat_count <= 16'd1;
                            state      <= st_fc_packet;
                        end
                    end
                    st_fc_packet: begin
                        if (beat_valid && beat_last) begin
                            state <= st_get_pattern;
                        end
                    end
                    default: begin
                        state <= st_get_pattern;
                    end
                endcase
            end
        end
    end

endmodule

// File: verilog/rdmx_addr_ring.sv
`timescale 1ns/1ns

module rdmx_addr_ring #(
    parameter int step_bytes = 256
) (
    input  logic        clk,
    input  logic        resetn,
    input  logic        advance,
    input  logic [63:0] base,
    input  logic [63:0] size,
    output logic [63:0] addr
);

    logic [63:0] offset;
    logic [63:0] next_offset;

    // Offset of the following packet if the ring does not wrap
    assign next_offset = offset + 64'(step_bytes);

    // Each advance moves one packet along, back to the start at the end
    always_ff @(posedge clk) begin
        if (!resetn) begin
            offset <= '0;
        end else if (advance) begin
            offset <= (next_offset < size) ? next_offset : '0;
        end
    end

    assign addr = base + offset;

endmodule

// File: verilog/rdmx_check_pkg.sv
package rdmx_check_pkg;

    //==========================================================================
    // Stream widths and RDMX protocol constants
    //==========================================================================

    // One Ethernet beat from the MAC
    localparam int beat_w     = 512;
    localparam int beat_bytes = beat_w / 8;

    // Every RDMX header carries this value in its magic field
    localparam logic [15:0] rdmx_magic = 16'h0122;

    // The IP length field is the payload size plus this many header bytes
    localparam int packet_overhead = 50;

    // Payload sizes of the two fixed-size packet classes
    localparam int md_payload_bytes = 128;
    localparam int fc_payload_bytes = 4;

    // Frame-counter packets carry flags of 1, the other classes carry 0
    localparam logic [7:0] fc_flags = 8'd1;

    //==========================================================================
    // Bit numbers in the error word
    //==========================================================================
    localparam int err_bad_fd_magic = 0;
    localparam int err_bad_fd_seq   = 1;
    localparam int err_bad_fd_psize = 2;
    localparam int err_bad_fd_taddr = 3;
    localparam int err_bad_fd       = 4;
    localparam int err_bad_fd_plen  = 5;
    localparam int err_bad_md_magic = 6;
    localparam int err_bad_md_seq   = 7;
    localparam int err_bad_md_psize = 8;
    localparam int err_bad_md_taddr = 9;
    localparam int err_bad_md       = 10;
    localparam int err_bad_md_plen  = 11;
    localparam int err_bad_fc_magic = 12;
    localparam int err_bad_fc_seq   = 13;
    localparam int err_bad_fc_psize = 14;
    localparam int err_bad_fc_taddr = 15;
    localparam int err_bad_fc       = 16;
    localparam int err_bad_fc_plen  = 17;
    // Bit 18 belonged to the source-QSFP check and stays unused
    localparam int err_bad_fd_flags = 19;
    localparam int err_bad_md_flags = 20;
    localparam int err_bad_fc_flags = 21;

    // Packet class whose header is under check
    typedef enum logic [1:0] {kind_fd, kind_md, kind_fc} pkt_kind_t;

    typedef enum logic [2:0] {
        st_get_pattern, st_fd_header, st_fd_packet, st_md_header,
        st_md_packet, st_fc_header, st_fc_packet
    } seq_state_t;

    // Big-endian header fields, first byte on the wire at the top
    typedef struct packed {
        logic [47:0] dst_mac;
        logic [47:0] src_mac;
        logic [15:0] frame_type;
        logic [15:0] ip4_ver_dsf;
        logic [15:0] ip4_length;
        logic [15:0] ip4_id;
        logic [15:0] ip4_flags;
        logic [15:0] ip4_ttl_prot;
        logic [15:0] ip4_checksum;
        logic [31:0] ip4_src_ip;
        logic [31:0] ip4_dst_ip;
        logic [15:0] udp_src_port;
        logic [15:0] udp_dst_port;
        logic [15:0] udp_length;
        logic [15:0] udp_checksum;
        logic [15:0] magic;
        logic [63:0] address;
        logic [15:0] seq_num;
        logic [31:0] user_fld;
        logic [7:0]  flags;
        logic [39:0] pad;
    } rdmx_hdr_t;

    // A byte-swapped beat is read as a header or as plain payload
    typedef union packed {
        rdmx_hdr_t         hdr;
        logic [beat_w-1:0] flat;
    } rdmx_beat_u;

endpackage

// File: verilog/rdmx_header_check.sv
`timescale 1ns/1ns

module rdmx_header_check import rdmx_check_pkg::*; #(
    parameter int fd_packet_bytes = 256
) (
    input  rdmx_beat_u  hdr,
    input  pkt_kind_t   hdr_kind,
    input  logic [15:0] expected_seq,
    input  logic [63:0] fd_addr,
    input  logic [63:0] md_addr,
    input  logic [63:0] fc_addr,
    output logic [4:0]  hdr_fail
);

    logic [15:0] exp_length;
    logic [7:0]  exp_flags;
    logic [63:0] exp_addr;

    // Expected values differ only by packet class
    always_comb begin
        case (hdr_kind)
            kind_fd: begin
                exp_length = 16'(fd_packet_bytes + packet_overhead);
                exp_flags  = 8'd0;
                exp_addr   = fd_addr;
            end
            kind_md: begin
                exp_length = 16'(md_payload_bytes + packet_overhead);
                exp_flags  = 8'd0;
                exp_addr   = md_addr;
            end
            default: begin
                exp_length = 16'(fc_payload_bytes + packet_overhead);
                exp_flags  = fc_flags;
                exp_addr   = fc_addr;
            end
        endcase
    end

    // Bit order from the bottom is magic, seq, psize, taddr, flags
    assign hdr_fail[0] = (hdr.hdr.magic != rdmx_magic);
    assign hdr_fail[1] = (hdr.hdr.seq_num != expected_seq);
    assign hdr_fail[2] = (hdr.hdr.ip4_length != exp_length);
    assign hdr_fail[3] = (hdr.hdr.address != exp_addr);
    assign hdr_fail[4] = (hdr.hdr.flags != exp_flags);

endmodule
